// File: verilog/dprx_trn_consts.svh
//////////////////////////////////////////////////////////////////////
// DP RX training checker constants
// Lane geometry, counter widths, symbol codes and APB offsets
//////////////////////////////////////////////////////////////////////

`ifndef DPRX_TRN_CONSTS_SVH
`define DPRX_TRN_CONSTS_SVH

`define DPRX_TRN_LANES       2          // Lanes in this build
`define DPRX_TRN_SPL         2          // Symbols per lane per clock
`define DPRX_TRN_LANE_CNT_W  3          // Active lane count field
`define DPRX_TRN_MATCH_W     16         // Match counter
`define DPRX_TRN_ERR_W       8          // Error counter
`define DPRX_TRN_TPS_STRIDE  4          // Bit spacing of pattern fields in REG_TPS

`define DPRX_TRN_APB_AW      8          // APB address
`define DPRX_TRN_APB_DW      32         // APB data

// 8b10b symbol codes used by the training patterns
`define DPRX_TRN_K28_5       8'hBC      // Control
`define DPRX_TRN_D10_2       8'h4A
`define DPRX_TRN_D11_6       8'hCB
`define DPRX_TRN_D30_3       8'h7E

`define DPRX_TRN_REG_LANES   8'h00
`define DPRX_TRN_REG_TPS     8'h04
`define DPRX_TRN_REG_MATCH0  8'h10
`define DPRX_TRN_REG_MATCH1  8'h14
`define DPRX_TRN_REG_ERR0    8'h20
`define DPRX_TRN_REG_ERR1    8'h24

`endif

// File: verilog/dprx_trn_pkg.sv
//////////////////////////////////////////////////////////////////////
// DP RX training checker types
// Pattern and register enums, per-lane symbol pair
//////////////////////////////////////////////////////////////////////

`include "dprx_trn_consts.svh"

package dprx_trn_pkg;

    // Training pattern checked by a lane
    typedef enum logic [1:0]
    {
        TPS_NONE = 2'd0,        // Idle, pass through
        TPS_1    = 2'd1,
        TPS_2    = 2'd2,
        TPS_3    = 2'd3
    } tps_t;

    // APB register offsets
    typedef enum logic [`DPRX_TRN_APB_AW-1:0]
    {
        REG_LANES  = `DPRX_TRN_REG_LANES,   // Active lanes, rw
        REG_TPS    = `DPRX_TRN_REG_TPS,     // Patterns, wo
        REG_MATCH0 = `DPRX_TRN_REG_MATCH0,
        REG_MATCH1 = `DPRX_TRN_REG_MATCH1,
        REG_ERR0   = `DPRX_TRN_REG_ERR0,
        REG_ERR1   = `DPRX_TRN_REG_ERR1
    } reg_addr_t;

    // One lane, one clock; symbol 0 in the low slot
    typedef struct packed
    {
        logic [`DPRX_TRN_SPL-1:0]       k;      // Control flags
        logic [`DPRX_TRN_SPL-1:0][7:0]  dat;    // Data bytes
    } lane_sym_t;

endpackage

// File: verilog/dprx_trn_cfg_if.sv
//////////////////////////////////////////////////////////////////////
// Lane configuration and status link
// Control block sets the pattern, the lane returns its counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dprx_trn_consts.svh"

interface dprx_trn_cfg_if
    import dprx_trn_pkg::*;
();

    logic                           set;        // Load pulse, one cycle
    tps_t                           tps;        // Pattern to load
    logic [`DPRX_TRN_MATCH_W-1:0]   match_cnt;  // Matching pairs
    logic [`DPRX_TRN_ERR_W-1:0]     err_cnt;    // Failing pairs

    // Register side
    modport ctrl
    (
        output set,
        output tps,
        input  match_cnt,
        input  err_cnt
    );

    // Checker side
    modport lane
    (
        input  set,
        input  tps,
        output match_cnt,
        output err_cnt
    );

endinterface

// File: verilog/dprx_trn_ctrl.sv
//////////////////////////////////////////////////////////////////////
// DP RX training control
// APB register file, lane set pulses and status read-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dprx_trn_consts.svh"

module dprx_trn_ctrl
    import dprx_trn_pkg::*;
(
    input  logic                            RST_IN,     // Clock
    input  logic                            CLK_IN,     // Reset, async high

    // APB slave
    input  logic [`DPRX_TRN_APB_AW-1:0]     paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`DPRX_TRN_APB_DW-1:0]     pwdata,
    output logic [`DPRX_TRN_APB_DW-1:0]     prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Lanes
    dprx_trn_cfg_if.ctrl                    lane_cfg [`DPRX_TRN_LANES]
);

    reg_addr_t                          addr;           // Decoded offset
    logic                               access;         // APB access phase
    logic                               wr_en;
    logic                               rd_en;
    logic                               addr_ok;        // Offset is mapped
    logic [`DPRX_TRN_LANE_CNT_W-1:0]    lane_count;     // Raw register value
    logic [`DPRX_TRN_LANE_CNT_W-1:0]    act_lanes;      // Clamped to 1..LANES
    logic [`DPRX_TRN_LANES-1:0]         set_q;
    tps_t                               tps_q [`DPRX_TRN_LANES];
    logic [`DPRX_TRN_MATCH_W-1:0]       match_cnt [`DPRX_TRN_LANES];
    logic [`DPRX_TRN_ERR_W-1:0]         err_cnt [`DPRX_TRN_LANES];

    assign addr   = reg_addr_t'(paddr);
    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign rd_en  = access && !pwrite;
    assign pready = 1'b1;                               // Zero wait states

    // Offset lookup
    always_comb
    begin
        case (addr)
            REG_LANES, REG_TPS, REG_MATCH0, REG_MATCH1, REG_ERR0, REG_ERR1:
                addr_ok = 1'b1;
            default:
                addr_ok = 1'b0;
        endcase
    end

    // Unmapped offset, or reading the write-only pattern register
    assign pslverr = access && (!addr_ok || (!pwrite && (addr == REG_TPS)));

    // 0 means one lane, anything above the build counts as all lanes
    always_comb
    begin
        if (lane_count == '0)
            act_lanes = `DPRX_TRN_LANE_CNT_W'(1);
        else if (lane_count > `DPRX_TRN_LANE_CNT_W'(`DPRX_TRN_LANES))
            act_lanes = `DPRX_TRN_LANE_CNT_W'(`DPRX_TRN_LANES);
        else
            act_lanes = lane_count;
    end

    // Active lanes register, takes effect at end of access
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            lane_count <= '0;
        else if (wr_en && (addr == REG_LANES))
            lane_count <= pwdata[`DPRX_TRN_LANE_CNT_W-1:0];
    end

    // Pattern fields and set pulse, one cycle after the access
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
        begin
            set_q <= '0;
            for (int i = 0; i < `DPRX_TRN_LANES; i++)
                tps_q[i] <= TPS_NONE;
        end
        else
        begin
            for (int i = 0; i < `DPRX_TRN_LANES; i++)
            begin
                set_q[i] <= wr_en && (addr == REG_TPS) && (i < int'(act_lanes));
                if (wr_en && (addr == REG_TPS))
                    tps_q[i] <= tps_t'(pwdata[i*`DPRX_TRN_TPS_STRIDE +: 2]);
            end
        end
    end

    // Lane links
    for (genvar i = 0; i < `DPRX_TRN_LANES; i++)
    begin : gen_lane_io
        assign lane_cfg[i].set = set_q[i];
        assign lane_cfg[i].tps = tps_q[i];
        assign match_cnt[i]    = lane_cfg[i].match_cnt;
        assign err_cnt[i]      = lane_cfg[i].err_cnt;
    end

    // Read mux, live counters
    always_comb
    begin
        prdata = '0;
        if (rd_en)
        begin
            case (addr)
                REG_LANES:  prdata[`DPRX_TRN_LANE_CNT_W-1:0] = lane_count;
                REG_MATCH0: prdata[`DPRX_TRN_MATCH_W-1:0]    = match_cnt[0];
                REG_MATCH1: prdata[`DPRX_TRN_MATCH_W-1:0]    = match_cnt[1];
                REG_ERR0:   prdata[`DPRX_TRN_ERR_W-1:0]      = err_cnt[0];
                REG_ERR1:   prdata[`DPRX_TRN_ERR_W-1:0]      = err_cnt[1];
                default:    ;                               // REG_TPS reads as 0
            endcase
        end
    end

endmodule

// File: verilog/dprx_trn_lane.sv
//////////////////////////////////////////////////////////////////////
// DP RX training lane
// Pattern checker with saturating counters and masked link output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dprx_trn_consts.svh"

module dprx_trn_lane
    import dprx_trn_pkg::*;
(
    input  logic            RST_IN,     // Clock
    input  logic            CLK_IN,     // Reset, async high

    dprx_trn_cfg_if.lane    cfg,        // Pattern in, counters out

    input  logic            lock,       // Receive link locked
    input  lane_sym_t       sym_in,
    output lane_sym_t       sym_out
);

    tps_t                           tps_q;      // Current pattern
    logic [`DPRX_TRN_MATCH_W-1:0]   match_q;
    logic [`DPRX_TRN_ERR_W-1:0]     err_q;
    logic                           pair_hit;   // Pair fits tps_q
    lane_sym_t                      sym_q;      // Output stage

    // One symbol against an expected code and control flag
    function automatic logic sym_is
    (
        input logic         k,
        input logic [7:0]   dat,
        input logic         k_exp,
        input logic [7:0]   dat_exp
    );
        return (k == k_exp) && (dat == dat_exp);
    endfunction

    // Pair check, symbol 0 first
    function automatic logic pair_ok
    (
        input tps_t         tps,
        input lane_sym_t    s
    );
        logic d10_pair;
        logic k_d11;
        logic k_d30;
        logic d30_pair;
        logic ok;

        d10_pair = sym_is(s.k[0], s.dat[0], 1'b0, `DPRX_TRN_D10_2) &&
                   sym_is(s.k[1], s.dat[1], 1'b0, `DPRX_TRN_D10_2);
        k_d11    = sym_is(s.k[0], s.dat[0], 1'b1, `DPRX_TRN_K28_5) &&
                   sym_is(s.k[1], s.dat[1], 1'b0, `DPRX_TRN_D11_6);
        k_d30    = sym_is(s.k[0], s.dat[0], 1'b1, `DPRX_TRN_K28_5) &&
                   sym_is(s.k[1], s.dat[1], 1'b0, `DPRX_TRN_D30_3);
        d30_pair = sym_is(s.k[0], s.dat[0], 1'b0, `DPRX_TRN_D30_3) &&
                   sym_is(s.k[1], s.dat[1], 1'b0, `DPRX_TRN_D30_3);

        case (tps)
            TPS_1:   ok = d10_pair;
            TPS_2:   ok = k_d11 || d10_pair;            // Comma pair or D10.2 pair
            TPS_3:   ok = k_d30 || d30_pair;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    assign pair_hit = pair_ok(tps_q, sym_in);

    // Pattern and counters
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
        begin
            tps_q   <= TPS_NONE;
            match_q <= '0;
            err_q   <= '0;
        end
        else if (cfg.set)
        begin
            // New pattern restarts the count
            tps_q   <= cfg.tps;
            match_q <= '0;
            err_q   <= '0;
        end
        else if (lock && (tps_q != TPS_NONE))
        begin
            if (pair_hit)
            begin
                if (match_q != '1)                      // Saturate
                    match_q <= match_q + 1'b1;
            end
            else if (err_q != '1)
                err_q <= err_q + 1'b1;
        end
    end

    assign cfg.match_cnt = match_q;
    assign cfg.err_cnt   = err_q;

    // Output stage, zeros while training
    always_ff @(posedge RST_IN or posedge CLK_IN)
    begin
        if (CLK_IN)
            sym_q <= '0;
        else if (tps_q == TPS_NONE)
            sym_q <= sym_in;                            // Idle pass through
        else
            sym_q <= '0;
    end

    assign sym_out = sym_q;

endmodule

// File: verilog/dprx_trn_top.sv
//////////////////////////////////////////////////////////////////////
// DP RX training checker top
// APB control block and one pattern checker per lane
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dprx_trn_consts.svh"

module dprx_trn_top
    import dprx_trn_pkg::*;
(
    input  logic                                        RST_IN,     // Clock
    input  logic                                        CLK_IN,     // Reset

    // APB slave
    input  logic [`DPRX_TRN_APB_AW-1:0]                 paddr,
    input  logic                                        psel,
    input  logic                                        penable,
    input  logic                                        pwrite,
    input  logic [`DPRX_TRN_APB_DW-1:0]                 pwdata,
    output logic [`DPRX_TRN_APB_DW-1:0]                 prdata,
    output logic                                        pready,
    output logic                                        pslverr,

    // Link in, lane major
    input  logic                                        lnk_lock,
    input  logic [`DPRX_TRN_LANES*`DPRX_TRN_SPL-1:0]    lnk_in_k,
    input  logic [`DPRX_TRN_LANES*`DPRX_TRN_SPL*8-1:0]  lnk_in_dat,

    // Link out, registered
    output logic [`DPRX_TRN_LANES*`DPRX_TRN_SPL-1:0]    lnk_out_k,
    output logic [`DPRX_TRN_LANES*`DPRX_TRN_SPL*8-1:0]  lnk_out_dat
);

    lane_sym_t  sym_to_lane   [`DPRX_TRN_LANES];
    lane_sym_t  sym_from_lane [`DPRX_TRN_LANES];

    // Control to lane links
    dprx_trn_cfg_if lane_cfg [`DPRX_TRN_LANES] ();

    dprx_trn_ctrl u_ctrl
    (
        .RST_IN   (RST_IN),
        .CLK_IN   (CLK_IN),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .lane_cfg (lane_cfg)
    );

    for (genvar i = 0; i < `DPRX_TRN_LANES; i++)
    begin : gen_lanes
        // Flat ports to lane pairs
        assign sym_to_lane[i].k   = lnk_in_k[i*`DPRX_TRN_SPL +: `DPRX_TRN_SPL];
        assign sym_to_lane[i].dat = lnk_in_dat[i*`DPRX_TRN_SPL*8 +: `DPRX_TRN_SPL*8];

        dprx_trn_lane u_lane
        (
            .RST_IN  (RST_IN),
            .CLK_IN  (CLK_IN),
            .cfg     (lane_cfg[i]),
            .lock    (lnk_lock),            // Shared lock
            .sym_in  (sym_to_lane[i]),
            .sym_out (sym_from_lane[i])
        );

        // And back
        assign lnk_out_k[i*`DPRX_TRN_SPL +: `DPRX_TRN_SPL]           = sym_from_lane[i].k;
        assign lnk_out_dat[i*`DPRX_TRN_SPL*8 +: `DPRX_TRN_SPL*8]     = sym_from_lane[i].dat;
    end

endmodule

// File: sim/dprx_trn_tb.sv
//////////////////////////////////////////////////////////////////////
// DP RX training checker testbench
// Table-driven APB and link stimulus checked against a pattern model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dprx_trn_consts.svh"

module dprx_trn_tb
    import dprx_trn_pkg::*;
();

    localparam int NL            = `DPRX_TRN_LANES;
    localparam int SPL           = `DPRX_TRN_SPL;
    localparam int SAT_MATCH     = (1 << `DPRX_TRN_MATCH_W) - 1;
    localparam int SAT_ERR       = (1 << `DPRX_TRN_ERR_W) - 1;
    localparam int CYCLE_TIMEOUT = 16;         // Access cycles before giving up on pready

    typedef enum logic [1:0] {OP_NONE, OP_WR, OP_RD} apb_op_t;
    typedef enum logic [2:0] {SM_LIT, SM_RAND, SM_D10, SM_KD11, SM_KD30, SM_D30} sym_mode_t;

    // One stimulus row; link modes and lock also hold during the APB cycles
    typedef struct packed
    {
        int             test;
        apb_op_t        op;
        logic [7:0]     addr;
        logic [31:0]    wdata;
        logic [31:0]    exp_rd;
        logic           exp_err;
        sym_mode_t      mode0;
        sym_mode_t      mode1;
        lane_sym_t      lit;                    // Pair for SM_LIT lanes
        int             cycles;                 // Link cycles after the APB op
        logic           lock;
    } row_t;

    logic                       clk;            // To RST_IN
    logic                       rst;            // To CLK_IN
    logic [7:0]                 paddr;
    logic                       psel, penable, pwrite;
    logic [31:0]                pwdata, prdata;
    logic                       pready, pslverr;
    logic                       lnk_lock;
    logic [NL*SPL-1:0]          lnk_in_k, lnk_out_k;
    logic [NL*SPL*8-1:0]        lnk_in_dat, lnk_out_dat;

    lane_sym_t                  drv_sym [NL];   // Pair on the link this cycle
    lane_sym_t                  exp_out [NL];   // Predicted output register
    logic [2:0]                 m_lane_count;
    logic                       m_set [NL];
    tps_t                       m_tps_next [NL];
    tps_t                       m_tps [NL];
    int                         m_match [NL];
    int                         m_err [NL];
    row_t                       table_q [$];
    row_t                       r;
    int                         errors, test_errors;
    logic                       timed_out;
    logic                       rd_seen, rd_err;
    logic [31:0]                rd_data, rd_model;
    string                      test_names [5] = '{"reset state", "one lane TPS1",
        "two lanes TPS2 TPS3", "training output and TPS_NONE", "error saturation"};

    dprx_trn_top u_dprx_trn_top
    (
        .RST_IN      (clk),
        .CLK_IN      (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .lnk_lock    (lnk_lock),
        .lnk_in_k    (lnk_in_k),
        .lnk_in_dat  (lnk_in_dat),
        .lnk_out_k   (lnk_out_k),
        .lnk_out_dat (lnk_out_dat)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("error at %0t ns: %s expected %0h actual %0h", $time, name, exp_val, act_val);
            errors++;
            test_errors++;
        end
    endtask

    function automatic void add_row(input int test, input apb_op_t op, input logic [7:0] addr,
        input logic [31:0] wdata, input logic [31:0] exp_rd, input logic exp_err,
        input sym_mode_t m0, input sym_mode_t m1, input logic [17:0] lit, input int cycles,
        input logic lock);
        row_t t;
        t = '{test, op, addr, wdata, exp_rd, exp_err, m0, m1, lane_sym_t'(lit), cycles, lock};
        table_q.push_back(t);
    endfunction

    // Symbol 0 sits in the low byte, control flags as {k1, k0}
    function automatic lane_sym_t make_pair(input sym_mode_t mode, input lane_sym_t lit);
        lane_sym_t  s;
        logic [31:0] rnd;
        s = lit;
        case (mode)
            SM_D10:  s = {2'b00, `DPRX_TRN_D10_2, `DPRX_TRN_D10_2};
            SM_KD11: s = {2'b01, `DPRX_TRN_D11_6, `DPRX_TRN_K28_5};
            SM_KD30: s = {2'b01, `DPRX_TRN_D30_3, `DPRX_TRN_K28_5};
            SM_D30:  s = {2'b00, `DPRX_TRN_D30_3, `DPRX_TRN_D30_3};
            SM_RAND:
            begin
                rnd   = $urandom();
                s.k   = 2'b00;                      // No comma, so no K-led pair
                s.dat = rnd[15:0];
                if (s.dat[0] == `DPRX_TRN_D10_2 || s.dat[0] == `DPRX_TRN_D30_3)
                    s.dat[0] = s.dat[0] ^ 8'h01;    // Break data pairs too
            end
            default: ;
        endcase
        return s;
    endfunction

    // Reference pattern rules
    function automatic logic pair_fits(input tps_t tps, input lane_sym_t s);
        logic [17:0] p;
        p = s;
        case (tps)
            TPS_1: return p == {2'b00, `DPRX_TRN_D10_2, `DPRX_TRN_D10_2};
            TPS_2: return p == {2'b01, `DPRX_TRN_D11_6, `DPRX_TRN_K28_5} ||
                          p == {2'b00, `DPRX_TRN_D10_2, `DPRX_TRN_D10_2};
            TPS_3: return p == {2'b01, `DPRX_TRN_D30_3, `DPRX_TRN_K28_5} ||
                          p == {2'b00, `DPRX_TRN_D30_3, `DPRX_TRN_D30_3};
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] addr);
        case (addr)
            REG_LANES:  return 32'(m_lane_count);
            REG_MATCH0: return 32'(m_match[0]);
            REG_MATCH1: return 32'(m_match[1]);
            REG_ERR0:   return 32'(m_err[0]);
            REG_ERR1:   return 32'(m_err[1]);
            default:    return 32'h0;               // Unmapped and TPS read as 0
        endcase
    endfunction

    // Model state update for one rising edge, from the inputs held at it
    task automatic model_edge();
        int act;
        act = (m_lane_count == 3'd0) ? 1 : (int'(m_lane_count) > NL) ? NL : int'(m_lane_count);
        for (int i = 0; i < NL; i++)
        begin
            exp_out[i] = (m_tps[i] == TPS_NONE) ? drv_sym[i] : '0;
            if (m_set[i])
            begin
                m_tps[i]   = m_tps_next[i];
                m_match[i] = 0;
                m_err[i]   = 0;
            end
            else if (lnk_lock && m_tps[i] != TPS_NONE)
            begin
                if (pair_fits(m_tps[i], drv_sym[i]))
                    m_match[i] = (m_match[i] < SAT_MATCH) ? m_match[i] + 1 : SAT_MATCH;
                else
                    m_err[i] = (m_err[i] < SAT_ERR) ? m_err[i] + 1 : SAT_ERR;
            end
            m_set[i] = psel && penable && pwrite && (paddr == REG_TPS) && (i < act);
            if (m_set[i])
                m_tps_next[i] = tps_t'(pwdata[i*`DPRX_TRN_TPS_STRIDE +: 2]);
        end
        if (psel && penable && pwrite && (paddr == REG_LANES))
            m_lane_count = pwdata[2:0];
    endtask

    // Drive at edge + 1 ns, optionally sample the bus mid-cycle, then check lnk_out
    task automatic run_cycle(input row_t rw, input logic sample_bus);
        for (int i = 0; i < NL; i++)
        begin
            drv_sym[i] = make_pair((i == 0) ? rw.mode0 : rw.mode1, rw.lit);
            lnk_in_k[i*SPL +: SPL]       = drv_sym[i].k;
            lnk_in_dat[i*SPL*8 +: SPL*8] = drv_sym[i].dat;
        end
        lnk_lock = rw.lock;
        if (sample_bus)
        begin
            #2;
            rd_data  = prdata;
            rd_err   = pslverr;
            rd_seen  = pready;
            rd_model = model_read(rw.addr);     // Counters as they stand this cycle
        end
        @(posedge clk);
        model_edge();
        #1;
        for (int i = 0; i < NL; i++)
        begin
            check_value($sformatf("lnk_out_k[%0d]", i), 32'(exp_out[i].k),
                        32'(lnk_out_k[i*SPL +: SPL]));
            check_value($sformatf("lnk_out_dat[%0d]", i), 32'(exp_out[i].dat),
                        32'(lnk_out_dat[i*SPL*8 +: SPL*8]));
        end
    endtask

    task automatic apb_access(input row_t rw);
        int wait_cycles;
        paddr   = rw.addr;
        pwrite  = (rw.op == OP_WR);
        pwdata  = rw.wdata;
        psel    = 1'b1;
        penable = 1'b0;
        run_cycle(rw, 1'b0);                    // Setup phase
        penable     = 1'b1;
        rd_seen     = 1'b0;
        wait_cycles = 0;
        while (!rd_seen && !timed_out)
        begin
            if (wait_cycles == CYCLE_TIMEOUT)
            begin
                $display("Timeout: pready stayed low for %0d cycles at %0t ns", wait_cycles, $time);
                timed_out = 1'b1;
            end
            else
            begin
                run_cycle(rw, 1'b1);
                wait_cycles++;
            end
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (rw.op == OP_RD)
        begin
            check_value($sformatf("prdata[%02h]", rw.addr), rw.exp_rd, rd_data);
            check_value($sformatf("prdata[%02h] vs model", rw.addr), rd_model, rd_data);
        end
        check_value("pslverr", 32'(rw.exp_err), 32'(rd_err));
    endtask

    function automatic void build_table();
        add_row(1, OP_RD, REG_LANES,  32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(1, OP_RD, REG_MATCH0, 32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(1, OP_RD, REG_MATCH1, 32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(1, OP_RD, REG_ERR0,   32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(1, OP_RD, REG_ERR1,   32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(1, OP_RD, 8'h08,      32'h0, 32'd0, 1'b1, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(1, OP_RD, REG_TPS,    32'h0, 32'd0, 1'b1, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(2, OP_WR, REG_LANES,  32'h1, 32'd0, 1'b0, SM_LIT, SM_RAND, 18'h0, 0, 1'b0);
        add_row(2, OP_WR, REG_TPS,   32'h11, 32'd0, 1'b0, SM_LIT, SM_RAND, 18'h0, 1, 1'b0);
        add_row(2, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_D10, SM_RAND, 18'h0, 20, 1'b1);
        add_row(2, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_RAND, SM_RAND, 18'h0, 7, 1'b1);
        add_row(2, OP_RD, REG_MATCH0, 32'h0, 32'd20, 1'b0, SM_LIT, SM_RAND, 18'h0, 0, 1'b0);
        add_row(2, OP_RD, REG_ERR0,   32'h0, 32'd7, 1'b0, SM_LIT, SM_RAND, 18'h0, 0, 1'b0);
        add_row(2, OP_RD, REG_MATCH1, 32'h0, 32'd0, 1'b0, SM_LIT, SM_RAND, 18'h0, 0, 1'b0);
        add_row(2, OP_RD, REG_ERR1,   32'h0, 32'd0, 1'b0, SM_LIT, SM_RAND, 18'h0, 0, 1'b0);
        add_row(3, OP_WR, REG_LANES,  32'h2, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(3, OP_WR, REG_TPS,   32'h32, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 1, 1'b0);
        add_row(3, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_KD11, SM_KD30, 18'h0, 5, 1'b1);
        add_row(3, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_D10, SM_D30, 18'h0, 4, 1'b1);
        add_row(3, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_RAND, SM_RAND, 18'h0, 6, 1'b0);
        add_row(3, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_KD30, SM_KD11, 18'h0, 3, 1'b1);
        add_row(3, OP_RD, REG_MATCH0, 32'h0, 32'd9, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(3, OP_RD, REG_MATCH1, 32'h0, 32'd9, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(3, OP_RD, REG_ERR0,   32'h0, 32'd3, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(3, OP_RD, REG_ERR1,   32'h0, 32'd3, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(4, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h2C3A5, 3, 1'b0);
        add_row(4, OP_WR, REG_TPS,   32'h30, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 1, 1'b0);
        add_row(4, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h15AA5, 4, 1'b1);
        add_row(4, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_RAND, SM_RAND, 18'h0, 5, 1'b0);
        add_row(4, OP_RD, REG_MATCH0, 32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(4, OP_RD, REG_ERR0,   32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(4, OP_RD, REG_ERR1,   32'h0, 32'd4, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(5, OP_WR, REG_TPS,   32'h01, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 1, 1'b0);
        add_row(5, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_D10, SM_LIT, 18'h0, 3, 1'b1);
        add_row(5, OP_NONE, 8'h00,    32'h0, 32'd0, 1'b0, SM_RAND, SM_RAND, 18'h0, 300, 1'b1);
        add_row(5, OP_RD, REG_ERR0,   32'h0, 32'd255, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(5, OP_RD, REG_MATCH0, 32'h0, 32'd3, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(5, OP_WR, REG_TPS,   32'h01, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 1, 1'b0);
        add_row(5, OP_RD, REG_ERR0,   32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
        add_row(5, OP_RD, REG_MATCH0, 32'h0, 32'd0, 1'b0, SM_LIT, SM_LIT, 18'h0, 0, 1'b0);
    endfunction

    initial
    begin
        errors      = 0;
        test_errors = 0;
        timed_out   = 1'b0;
        void'($urandom(16));                    // Fixed seed
        rst      = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        lnk_lock = 1'b0;
        lnk_in_k = '0;
        lnk_in_dat   = '0;
        m_lane_count = '0;
        for (int i = 0; i < NL; i++)
        begin
            drv_sym[i]    = '0;
            exp_out[i]    = '0;
            m_set[i]      = 1'b0;
            m_tps[i]      = TPS_NONE;
            m_tps_next[i] = TPS_NONE;
            m_match[i]    = 0;
            m_err[i]      = 0;
        end
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("lnk_out_k", 32'h0, 32'(lnk_out_k));   // Output stage cleared
        check_value("lnk_out_dat", 32'h0, 32'(lnk_out_dat));
        for (int n = 0; n < table_q.size() && !timed_out; n++)
        begin
            r = table_q[n];
            if (r.op != OP_NONE)
                apb_access(r);
            for (int c = 0; c < r.cycles && !timed_out; c++)
                run_cycle(r, 1'b0);
            if (!timed_out && (n == table_q.size() - 1 || table_q[n+1].test != r.test))
            begin
                $display("test %0d %s: %s, %0d errors", r.test, test_names[r.test-1],
                         (test_errors == 0) ? "ok" : "mismatches", test_errors);
                test_errors = 0;
            end
        end
        $display("%0d rows applied, %0d errors, timeout %0d", table_q.size(), errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: dprx_trn.f
+incdir+verilog
verilog/dprx_trn_pkg.sv
verilog/dprx_trn_cfg_if.sv
verilog/dprx_trn_ctrl.sv
verilog/dprx_trn_lane.sv
verilog/dprx_trn_top.sv
sim/dprx_trn_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DP RX training checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f dprx_trn.f --top-module dprx_trn_tb --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/Vdprx_trn_tb)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints the pass line only when every check held
if printf '%s\n' "$sim_out" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
